/* hw/rvseed_mem_pkg.sv */
package rvseed_mem_pkg;

    // data path width of request ports and axi data bus
    parameter int XLEN = 64;
    // byte address width
    parameter int ADDR_W = 32;
    // one strobe bit per data byte
    parameter int STRB_W = XLEN / 8;

    // access size, encoded like axi size for a 64-bit bus
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } acc_size_e;

    // axi response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // bridge read channel FSM
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    // bridge write channel FSM
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR_DATA,
        WR_RESP
    } wr_state_e;

    // sram slave FSM
    typedef enum logic [1:0] {
        SLV_IDLE,
        SLV_READ_RESP,
        SLV_WRITE_RESP
    } slv_state_e;

endpackage

/* hw/mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if;
    import rvseed_mem_pkg::*;

    // request side, held stable until ready
    logic               valid;
    logic               write;
    logic [ADDR_W-1:0]  addr;
    logic [XLEN-1:0]    wdata;
    acc_size_e          size;
    // response side, one cycle pulse with data
    logic               ready;
    logic [XLEN-1:0]    rdata;
    axi_resp_e          resp;

    modport requester (
        output valid, write, addr, wdata, size,
        input  ready, rdata, resp
    );

    modport responder (
        input  valid, write, addr, wdata, size,
        output ready, rdata, resp
    );

endinterface

/* hw/axi_lite4_if.sv */
`timescale 1ns/1ps

interface axi_lite4_if;
    import rvseed_mem_pkg::*;

    // write address channel
    logic               aw_valid;
    logic               aw_ready;
    logic [ADDR_W-1:0]  aw_addr;
    logic [2:0]         aw_size;

    // write data channel, single beat
    logic               w_valid;
    logic               w_ready;
    logic [XLEN-1:0]    w_data;
    logic [STRB_W-1:0]  w_strb;
    logic               w_last;

    // write response channel
    logic               b_valid;
    logic               b_ready;
    axi_resp_e          b_resp;

    // read address channel
    logic               ar_valid;
    logic               ar_ready;
    logic [ADDR_W-1:0]  ar_addr;
    logic [2:0]         ar_size;

    // read data channel, single beat
    logic               r_valid;
    logic               r_ready;
    logic [XLEN-1:0]    r_data;
    axi_resp_e          r_resp;
    logic               r_last;

    modport master (
        output aw_valid, aw_addr, aw_size,
        output w_valid, w_data, w_strb, w_last,
        output b_ready,
        output ar_valid, ar_addr, ar_size,
        output r_ready,
        input  aw_ready, w_ready, b_valid, b_resp,
        input  ar_ready, r_valid, r_data, r_resp, r_last
    );

    modport slave (
        input  aw_valid, aw_addr, aw_size,
        input  w_valid, w_data, w_strb, w_last,
        input  b_ready,
        input  ar_valid, ar_addr, ar_size,
        input  r_ready,
        output aw_ready, w_ready, b_valid, b_resp,
        output ar_ready, r_valid, r_data, r_resp, r_last
    );

endinterface

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input logic             clock,
    input logic             reset_n,
    mem_req_if.responder    fetch_port,
    mem_req_if.responder    lsu_port,
    mem_req_if.requester    bus_port
);
    import rvseed_mem_pkg::*;

    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_FETCH,
        GNT_LSU
    } grant_e;

    // grant held until bridge returns ready
    grant_e grant_q;
    // effective grant this cycle
    grant_e grant;
    // set when lsu was served last
    logic   last_lsu;

    // free bus picks in the same cycle, held grant wins otherwise
    always_comb begin
        grant = grant_q;
        if (grant_q == GNT_NONE) begin
            if (fetch_port.valid && lsu_port.valid) begin
                // round robin, port not served last goes first
                grant = last_lsu ? GNT_FETCH : GNT_LSU;
            end else if (fetch_port.valid) begin
                grant = GNT_FETCH;
            end else if (lsu_port.valid) begin
                grant = GNT_LSU;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            grant_q  <= GNT_NONE;
            last_lsu <= 1'b0;
        end else if (bus_port.ready) begin
            // transaction done, release lock
            grant_q  <= GNT_NONE;
            last_lsu <= (grant == GNT_LSU);
        end else if (bus_port.valid) begin
            grant_q  <= grant;
        end
    end

    // forward granted request fields
    assign bus_port.valid = (grant == GNT_FETCH) ? fetch_port.valid :
                            (grant == GNT_LSU)   ? lsu_port.valid   : 1'b0;
    assign bus_port.write = (grant == GNT_LSU) ? lsu_port.write : fetch_port.write;
    assign bus_port.addr  = (grant == GNT_LSU) ? lsu_port.addr  : fetch_port.addr;
    assign bus_port.wdata = (grant == GNT_LSU) ? lsu_port.wdata : fetch_port.wdata;
    assign bus_port.size  = (grant == GNT_LSU) ? lsu_port.size  : fetch_port.size;

    // response only to the granted port
    assign fetch_port.ready = bus_port.ready && (grant == GNT_FETCH);
    assign fetch_port.rdata = (grant == GNT_FETCH) ? bus_port.rdata : '0;
    assign fetch_port.resp  = (grant == GNT_FETCH) ? bus_port.resp : RESP_OKAY;
    assign lsu_port.ready   = bus_port.ready && (grant == GNT_LSU);
    assign lsu_port.rdata   = (grant == GNT_LSU) ? bus_port.rdata : '0;
    assign lsu_port.resp    = (grant == GNT_LSU) ? bus_port.resp : RESP_OKAY;

    // grant and request stay put while pending on the bus
    a_grant_stable: assert property (@(posedge clock) disable iff (!reset_n)
        bus_port.valid && !bus_port.ready |=> bus_port.valid && grant == $past(grant));

    // bridge only completes a request that was locked in
    a_ready_has_grant: assert property (@(posedge clock) disable iff (!reset_n)
        bus_port.ready |-> grant_q != GNT_NONE);

endmodule

/* hw/axi_master_bridge.sv */
`timescale 1ns/1ps

module axi_master_bridge (
    input logic             clock,
    input logic             reset_n,
    mem_req_if.responder    req,
    axi_lite4_if.master     axi
);
    import rvseed_mem_pkg::*;

    rd_state_e          rd_state;
    wr_state_e          wr_state;
    // captured request
    logic [ADDR_W-1:0]  addr_q;
    acc_size_e          size_q;
    logic [XLEN-1:0]    wdata_q;
    // per channel done flags for the write pair
    logic               aw_done;
    logic               w_done;
    // response back to requester
    logic               ready_q;
    logic [XLEN-1:0]    rdata_q;
    axi_resp_e          resp_q;
    // lane math
    logic [5:0]         bit_off;
    logic [STRB_W-1:0]  size_strb;
    logic [XLEN-1:0]    size_mask;
    logic               misaligned;
    logic               accept;
    logic               aw_hs;
    logic               w_hs;
    logic               b_hs;
    logic               ar_hs;
    logic               r_done;
    logic               wr_sent;

    // both machines idle, and skip the cycle where ready is still out
    assign accept = req.valid && !ready_q && rd_state == RD_IDLE && wr_state == WR_IDLE;

    assign aw_hs   = axi.aw_valid && axi.aw_ready;
    assign w_hs    = axi.w_valid && axi.w_ready;
    assign b_hs    = axi.b_valid && axi.b_ready;
    assign ar_hs   = axi.ar_valid && axi.ar_ready;
    assign r_done  = axi.r_valid && axi.r_ready && axi.r_last;
    assign wr_sent = (aw_done || aw_hs) && (w_done || w_hs);

    // byte lane from low address bits
    assign bit_off = {addr_q[2:0], 3'b000};

    always_comb begin
        case (size_q)
            SIZE_BYTE: begin
                size_strb = 8'h01;
                size_mask = 64'h0000_0000_0000_00ff;
            end
            SIZE_HALF: begin
                size_strb = 8'h03;
                size_mask = 64'h0000_0000_0000_ffff;
            end
            SIZE_WORD: begin
                size_strb = 8'h0f;
                size_mask = 64'h0000_0000_ffff_ffff;
            end
            default: begin
                size_strb = 8'hff;
                size_mask = 64'hffff_ffff_ffff_ffff;
            end
        endcase
    end

    // incoming request must sit inside one 8-byte word
    always_comb begin
        case (req.size)
            SIZE_HALF:   misaligned = req.addr[0];
            SIZE_WORD:   misaligned = |req.addr[1:0];
            SIZE_DOUBLE: misaligned = |req.addr[2:0];
            default:     misaligned = 1'b0;
        endcase
    end

    // read FSM
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: if (accept && !req.write) rd_state <= RD_ADDR;
                RD_ADDR: if (ar_hs) rd_state <= RD_DATA;
                RD_DATA: if (r_done) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // write FSM, aw and w go out together
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            wr_state <= WR_IDLE;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (accept && req.write) wr_state <= WR_ADDR_DATA;
                end
                WR_ADDR_DATA: begin
                    aw_done <= aw_done || aw_hs;
                    w_done  <= w_done || w_hs;
                    if (wr_sent) wr_state <= WR_RESP;
                end
                WR_RESP: if (b_hs) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // capture request on acceptance
    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q  <= req.addr;
            size_q  <= req.size;
            wdata_q <= req.wdata;
        end
    end

    // ready pulses the cycle after r or b handshake
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= r_done || b_hs;
        end
    end

    always_ff @(posedge clock) begin
        if (r_done) begin
            // shift addressed lanes down, zero extend
            rdata_q <= (axi.r_data >> bit_off) & size_mask;
            resp_q  <= axi.r_resp;
        end else if (b_hs) begin
            rdata_q <= '0;
            resp_q  <= axi.b_resp;
        end
    end

    assign req.ready = ready_q;
    assign req.rdata = rdata_q;
    assign req.resp  = resp_q;

    // read channels
    assign axi.ar_valid = (rd_state == RD_ADDR);
    assign axi.ar_addr  = addr_q;
    assign axi.ar_size  = {1'b0, size_q};
    assign axi.r_ready  = (rd_state == RD_DATA);

    // write channels, data moved to its byte lane
    assign axi.aw_valid = (wr_state == WR_ADDR_DATA) && !aw_done;
    assign axi.aw_addr  = addr_q;
    assign axi.aw_size  = {1'b0, size_q};
    assign axi.w_valid  = (wr_state == WR_ADDR_DATA) && !w_done;
    assign axi.w_data   = wdata_q << bit_off;
    assign axi.w_strb   = size_strb << addr_q[2:0];
    assign axi.w_last   = 1'b1;
    assign axi.b_ready  = (wr_state == WR_RESP);

    // requesters never hand over an access crossing a word
    a_req_aligned: assert property (@(posedge clock) disable iff (!reset_n)
        accept |-> !misaligned);

endmodule

/* hw/axi_sram.sv */
`timescale 1ns/1ps

module axi_sram #(
    parameter int MEM_WORDS = 1024
) (
    input logic         clock,
    input logic         reset_n,
    axi_lite4_if.slave  axi
);
    import rvseed_mem_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);
    // depth in the width of a word address
    localparam logic [ADDR_W-4:0] DEPTH = (ADDR_W-3)'(MEM_WORDS);

    // word array, one byte per strobe bit
    logic [XLEN-1:0]    mem [MEM_WORDS];
    slv_state_e         state;
    logic [XLEN-1:0]    r_data_q;
    axi_resp_e          r_resp_q;
    axi_resp_e          b_resp_q;
    logic [ADDR_W-4:0]  rd_word;
    logic [ADDR_W-4:0]  wr_word;
    logic               rd_ok;
    logic               wr_ok;
    logic               ar_hs;
    logic               wr_hs;

    // word index of each address
    assign rd_word = axi.ar_addr[ADDR_W-1:3];
    assign wr_word = axi.aw_addr[ADDR_W-1:3];
    // in range and no wider than the bus
    assign rd_ok = (rd_word < DEPTH) && (axi.ar_size <= 3'd3);
    assign wr_ok = (wr_word < DEPTH) && (axi.aw_size <= 3'd3);

    // all address and data ready while idle
    assign axi.ar_ready = (state == SLV_IDLE);
    assign axi.aw_ready = (state == SLV_IDLE);
    assign axi.w_ready  = (state == SLV_IDLE);

    assign ar_hs = axi.ar_valid && axi.ar_ready;
    // write needs address and data in the same cycle
    assign wr_hs = axi.aw_valid && axi.aw_ready && axi.w_valid && axi.w_ready;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= SLV_IDLE;
        end else begin
            case (state)
                SLV_IDLE: begin
                    if (ar_hs) begin
                        state <= SLV_READ_RESP;
                    end else if (wr_hs) begin
                        state <= SLV_WRITE_RESP;
                    end
                end
                SLV_READ_RESP: if (axi.r_ready) state <= SLV_IDLE;
                SLV_WRITE_RESP: if (axi.b_ready) state <= SLV_IDLE;
                default: state <= SLV_IDLE;
            endcase
        end
    end

    // read capture, zero data on error
    always_ff @(posedge clock) begin
        if (ar_hs) begin
            r_data_q <= rd_ok ? mem[rd_word[IDX_W-1:0]] : '0;
            r_resp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // byte masked write, dropped when out of range
    always_ff @(posedge clock) begin
        if (wr_hs) begin
            b_resp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            if (wr_ok) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (axi.w_strb[b]) begin
                        mem[wr_word[IDX_W-1:0]][b*8 +: 8] <= axi.w_data[b*8 +: 8];
                    end
                end
            end
        end
    end

    // responses held until master takes them
    assign axi.r_valid = (state == SLV_READ_RESP);
    assign axi.r_data  = r_data_q;
    assign axi.r_resp  = r_resp_q;
    assign axi.r_last  = 1'b1;
    assign axi.b_valid = (state == SLV_WRITE_RESP);
    assign axi.b_resp  = b_resp_q;

    // master keeps a single transaction in flight
    a_one_outstanding: assert property (@(posedge clock) disable iff (!reset_n)
        !(axi.ar_valid && (axi.aw_valid || axi.w_valid)));

    // write address comes with its one and only data beat
    a_single_beat: assert property (@(posedge clock) disable iff (!reset_n)
        axi.aw_valid |-> axi.w_valid && axi.w_last);

endmodule

/* hw/rvseed_mem_top.sv */
`timescale 1ns/1ps

module rvseed_mem_top #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                                clock,
    input  logic                                reset_n,
    // instruction fetch port
    input  logic                                if_valid_i,
    input  logic                                if_write_i,
    input  logic [rvseed_mem_pkg::ADDR_W-1:0]   if_addr_i,
    input  logic [rvseed_mem_pkg::XLEN-1:0]     if_wdata_i,
    input  rvseed_mem_pkg::acc_size_e           if_size_i,
    output logic                                if_ready_o,
    output logic [rvseed_mem_pkg::XLEN-1:0]     if_rdata_o,
    output rvseed_mem_pkg::axi_resp_e           if_resp_o,
    // load/store port
    input  logic                                ls_valid_i,
    input  logic                                ls_write_i,
    input  logic [rvseed_mem_pkg::ADDR_W-1:0]   ls_addr_i,
    input  logic [rvseed_mem_pkg::XLEN-1:0]     ls_wdata_i,
    input  rvseed_mem_pkg::acc_size_e           ls_size_i,
    output logic                                ls_ready_o,
    output logic [rvseed_mem_pkg::XLEN-1:0]     ls_rdata_o,
    output rvseed_mem_pkg::axi_resp_e           ls_resp_o
);

    mem_req_if      if_bus ();
    mem_req_if      ls_bus ();
    // arbiter to bridge
    mem_req_if      arb_bus ();
    // bridge to sram
    axi_lite4_if    axi_bus ();

    // fetch plain ports into interface
    assign if_bus.valid = if_valid_i;
    assign if_bus.write = if_write_i;
    assign if_bus.addr  = if_addr_i;
    assign if_bus.wdata = if_wdata_i;
    assign if_bus.size  = if_size_i;
    assign if_ready_o   = if_bus.ready;
    assign if_rdata_o   = if_bus.rdata;
    assign if_resp_o    = if_bus.resp;

    // load/store plain ports into interface
    assign ls_bus.valid = ls_valid_i;
    assign ls_bus.write = ls_write_i;
    assign ls_bus.addr  = ls_addr_i;
    assign ls_bus.wdata = ls_wdata_i;
    assign ls_bus.size  = ls_size_i;
    assign ls_ready_o   = ls_bus.ready;
    assign ls_rdata_o   = ls_bus.rdata;
    assign ls_resp_o    = ls_bus.resp;

    mem_arbiter mem_arbiter_inst (
        .clock      (clock),
        .reset_n    (reset_n),
        .fetch_port (if_bus),
        .lsu_port   (ls_bus),
        .bus_port   (arb_bus)
    );

    axi_master_bridge axi_master_bridge_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .req     (arb_bus),
        .axi     (axi_bus)
    );

    axi_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) axi_sram_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .axi     (axi_bus)
    );

endmodule

/* tests/tb_mem_top.sv */
`timescale 1ns/1ps

module tb_mem_top;
    import rvseed_mem_pkg::*;

    localparam int MEM_WORDS = 1024;
    // ops issued over all six tests
    localparam int OPS_TOTAL = 1 + 49 + 16 + 12 + 4 + 332;
    // 20 cycles per op covers a wait behind the other port
    localparam int WATCHDOG_CYCLES = OPS_TOTAL * 20 + 200;
    localparam bit PORT_IF = 1'b0;
    localparam bit PORT_LS = 1'b1;

    logic               clock;
    logic               reset_n;
    logic               if_valid_i;
    logic               if_write_i;
    logic [ADDR_W-1:0]  if_addr_i;
    logic [XLEN-1:0]    if_wdata_i;
    acc_size_e          if_size_i;
    logic               if_ready_o;
    logic [XLEN-1:0]    if_rdata_o;
    axi_resp_e          if_resp_o;
    logic               ls_valid_i;
    logic               ls_write_i;
    logic [ADDR_W-1:0]  ls_addr_i;
    logic [XLEN-1:0]    ls_wdata_i;
    acc_size_e          ls_size_i;
    logic               ls_ready_o;
    logic [XLEN-1:0]    ls_rdata_o;
    axi_resp_e          ls_resp_o;

    // byte image of the sram, absent bytes read as zero
    logic [7:0]         ref_mem [logic [31:0]];
    // request in flight per port, indexed by PORT_IF / PORT_LS
    logic               pend_write [2];
    logic [31:0]        pend_addr [2];
    acc_size_e          pend_size [2];
    logic [63:0]        pend_wdata [2];
    int                 issued [2] = '{0, 0};
    int                 answered [2] = '{0, 0};

    int                 seq_errors = 0;
    int                 cmp_errors = 0;
    int                 checks = 0;
    int                 tests_failed = 0;
    int                 test_num = 0;
    int                 test_base = 0;
    string              test_name;
    bit                 last_served;
    // ports in the order their ready arrived
    bit                 done_order [$];

    rvseed_mem_top #(
        .MEM_WORDS (MEM_WORDS)
    ) rvseed_mem_top_inst (
        .clock      (clock),
        .reset_n    (reset_n),
        .if_valid_i (if_valid_i),
        .if_write_i (if_write_i),
        .if_addr_i  (if_addr_i),
        .if_wdata_i (if_wdata_i),
        .if_size_i  (if_size_i),
        .if_ready_o (if_ready_o),
        .if_rdata_o (if_rdata_o),
        .if_resp_o  (if_resp_o),
        .ls_valid_i (ls_valid_i),
        .ls_write_i (ls_write_i),
        .ls_addr_i  (ls_addr_i),
        .ls_wdata_i (ls_wdata_i),
        .ls_size_i  (ls_size_i),
        .ls_ready_o (ls_ready_o),
        .ls_rdata_o (ls_rdata_o),
        .ls_resp_o  (ls_resp_o)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // word index past the sram depth means slverr
    function automatic bit in_range(input logic [31:0] addr);
        return (addr >> 3) < 32'(MEM_WORDS);
    endfunction

    // expected read, little endian, zero extended from the addressed bytes
    function automatic logic [63:0] ref_read(input logic [31:0] addr, input acc_size_e size,
                                             output axi_resp_e resp);
        logic [63:0] data;
        logic [31:0] a;
        data = '0;
        resp = RESP_SLVERR;
        if (in_range(addr)) begin
            resp = RESP_OKAY;
            for (int i = 0; i < (1 << size); i++) begin
                a = addr + 32'(i);
                if (ref_mem.exists(a)) data[i*8 +: 8] = ref_mem[a];
            end
        end
        return data;
    endfunction

    // out of range writes leave the image alone
    function automatic axi_resp_e ref_write(input logic [31:0] addr, input acc_size_e size,
                                            input logic [63:0] wdata);
        if (!in_range(addr)) return RESP_SLVERR;
        for (int i = 0; i < (1 << size); i++) begin
            ref_mem[addr + 32'(i)] = wdata[i*8 +: 8];
        end
        return RESP_OKAY;
    endfunction

    task automatic check_response(input bit port, input logic [63:0] rdata,
                                  input axi_resp_e resp);
        logic [63:0] exp_data;
        axi_resp_e   exp_resp;
        string       name;
        name = port ? "ls" : "if";
        if (answered[port] >= issued[port]) begin
            $display("%s port raised ready with no request outstanding", name);
            cmp_errors++;
            return;
        end
        answered[port]++;
        // writes answer with zero data
        if (pend_write[port]) begin
            exp_resp = ref_write(pend_addr[port], pend_size[port], pend_wdata[port]);
            exp_data = '0;
        end else begin
            exp_data = ref_read(pend_addr[port], pend_size[port], exp_resp);
        end
        checks++;
        if (rdata !== exp_data) begin
            $display("[ERROR] %s_rdata_o: expected %h, got %h at addr %h", name, exp_data,
                     rdata, pend_addr[port]);
            cmp_errors++;
        end
        if (resp !== exp_resp) begin
            $display("[ERROR] %s_resp_o: expected %h, got %h at addr %h", name, exp_resp,
                     resp, pend_addr[port]);
            cmp_errors++;
        end
    endtask

    // fetch port responses
    always @(posedge clock) begin
        if (if_ready_o === 1'b1) check_response(PORT_IF, if_rdata_o, if_resp_o);
    end

    // load/store port responses
    always @(posedge clock) begin
        if (ls_ready_o === 1'b1) check_response(PORT_LS, ls_rdata_o, ls_resp_o);
    end

    // raise valid, hold until ready, return cycles from valid to ready
    task automatic run_op(input bit port, input logic wr, input logic [31:0] addr,
                          input acc_size_e size, input logic [63:0] wdata, output int cycles);
        logic rdy;
        @(posedge clock);
        pend_write[port] = wr;
        pend_addr[port]  = addr;
        pend_size[port]  = size;
        pend_wdata[port] = wdata;
        issued[port]++;
        if (port == PORT_LS) begin
            ls_valid_i <= 1'b1;
            ls_write_i <= wr;
            ls_addr_i  <= addr;
            ls_size_i  <= size;
            ls_wdata_i <= wdata;
        end else begin
            if_valid_i <= 1'b1;
            if_write_i <= wr;
            if_addr_i  <= addr;
            if_size_i  <= size;
            if_wdata_i <= wdata;
        end
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            rdy = (port == PORT_LS) ? ls_ready_o : if_ready_o;
        end while (rdy !== 1'b1);
        if (port == PORT_LS) ls_valid_i <= 1'b0;
        else if_valid_i <= 1'b0;
        last_served = port;
        done_order.push_back(port);
    endtask

    // uncontended access, fixed 4 cycle latency
    task automatic single_access(input bit port, input logic wr, input logic [31:0] addr,
                                 input acc_size_e size, input logic [63:0] wdata);
        int cyc;
        run_op(port, wr, addr, size, wdata, cyc);
        if (cyc != 4) begin
            $display("%s port took %0d cycles from valid to ready, expected 4",
                     port ? "ls" : "if", cyc);
            seq_errors++;
        end
    endtask

    // aligned mixed traffic inside the preloaded window at 0x800
    task automatic random_ops(input bit port, input int count);
        logic [31:0] addr;
        logic [1:0]  s;
        int          cyc;
        for (int n = 0; n < count; n++) begin
            s = 2'($urandom % 4);
            addr = 32'h800 + ($urandom % 256);
            addr = addr & ~((32'd1 << s) - 32'd1);
            run_op(port, 1'($urandom % 2), addr, acc_size_e'(s), {$urandom, $urandom}, cyc);
            repeat ($urandom % 3) @(posedge clock);
        end
    endtask

    task automatic begin_test(input string name);
        test_num++;
        test_name = name;
        test_base = seq_errors + cmp_errors;
    endtask

    task automatic end_test();
        int errs;
        // last compare ran on the previous rising edge
        @(negedge clock);
        errs = seq_errors + cmp_errors - test_base;
        if (errs != 0) tests_failed++;
        $display("test %0d %s: %s, %0d errors", test_num, test_name,
                 (errs == 0) ? "pass" : "fail", errs);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog expired after %0d cycles, a request never completed",
                 WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic [31:0] base;
        logic [31:0] oor;
        acc_size_e   sz;
        bit          expect_first;
        bit          solo_port;
        int          cyc_if;
        int          cyc_ls;

        void'($urandom(32'h147a));
        last_served = PORT_IF;
        reset_n    <= 1'b0;
        if_valid_i <= 1'b0;
        if_write_i <= 1'b0;
        if_addr_i  <= '0;
        if_wdata_i <= '0;
        if_size_i  <= SIZE_BYTE;
        ls_valid_i <= 1'b0;
        ls_write_i <= 1'b0;
        ls_addr_i  <= '0;
        ls_wdata_i <= '0;
        ls_size_i  <= SIZE_BYTE;
        repeat (5) @(posedge clock);
        reset_n <= 1'b1;

        begin_test("idle after reset");
        repeat (10) begin
            @(posedge clock);
            if (if_ready_o !== 1'b0) begin
                $display("[ERROR] if_ready_o: expected 0, got %h", if_ready_o);
                seq_errors++;
            end
            if (ls_ready_o !== 1'b0) begin
                $display("[ERROR] ls_ready_o: expected 0, got %h", ls_ready_o);
                seq_errors++;
            end
        end
        single_access(PORT_LS, 1'b0, 32'h300, SIZE_DOUBLE, '0);
        end_test();

        begin_test("ls sizes at every lane");
        for (int s = 0; s < 4; s++) begin
            sz = acc_size_e'(2'(s));
            base = 32'h100 + 32'(s * 8);
            // known neighbours first
            single_access(PORT_LS, 1'b1, base, SIZE_DOUBLE, {$urandom, $urandom});
            for (int off = 0; off < 8; off += (1 << s)) begin
                single_access(PORT_LS, 1'b1, base + 32'(off), sz, {$urandom, $urandom});
                single_access(PORT_LS, 1'b0, base + 32'(off), sz, '0);
                single_access(PORT_LS, 1'b0, base, SIZE_DOUBLE, '0);
            end
        end
        end_test();

        begin_test("if reads ls writes");
        for (int w = 0; w < 8; w++) begin
            single_access(PORT_LS, 1'b1, 32'h200 + 32'(w * 8), SIZE_DOUBLE, {$urandom, $urandom});
        end
        for (int w = 0; w < 8; w++) begin
            single_access(PORT_IF, 1'b0, 32'h200 + 32'(w * 8), SIZE_DOUBLE, '0);
        end
        end_test();

        begin_test("contention round robin");
        for (int r = 0; r < 4; r++) begin
            // solo op on alternating ports flips the expected winner
            solo_port = (r % 2 == 0) ? PORT_IF : PORT_LS;
            single_access(solo_port, 1'b0, 32'h200, SIZE_DOUBLE, '0);
            expect_first = ~last_served;
            done_order.delete();
            fork
                run_op(PORT_IF, 1'b0, 32'h208, SIZE_DOUBLE, '0, cyc_if);
                run_op(PORT_LS, 1'b1, 32'h210 + 32'(r * 8), SIZE_WORD,
                       {$urandom, $urandom}, cyc_ls);
            join
            if (done_order.size() != 2 || done_order[0] != expect_first) begin
                $display("contention round %0d: first ready did not go to the %s port", r,
                         expect_first ? "ls" : "if");
                seq_errors++;
            end
        end
        end_test();

        begin_test("out of range slverr");
        // aliases to word 8 if the index were truncated
        oor = 32'(MEM_WORDS * 8) + 32'h40;
        single_access(PORT_LS, 1'b1, 32'h40, SIZE_DOUBLE, 64'h0123_4567_89ab_cdef);
        single_access(PORT_LS, 1'b1, oor, SIZE_DOUBLE, 64'hfedc_ba98_7654_3210);
        single_access(PORT_LS, 1'b0, oor, SIZE_DOUBLE, '0);
        single_access(PORT_IF, 1'b0, 32'h40, SIZE_DOUBLE, '0);
        end_test();

        begin_test("random mixed traffic");
        for (int w = 0; w < 32; w++) begin
            single_access(PORT_LS, 1'b1, 32'h800 + 32'(w * 8), SIZE_DOUBLE, {$urandom, $urandom});
        end
        fork
            random_ops(PORT_IF, 150);
            random_ops(PORT_LS, 150);
        join
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors", test_num, tests_failed,
                 checks, seq_errors + cmp_errors);
        if (seq_errors + cmp_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
hw/rvseed_mem_pkg.sv
hw/mem_req_if.sv
hw/axi_lite4_if.sv
hw/mem_arbiter.sv
hw/axi_master_bridge.sv
hw/axi_sram.sv
hw/rvseed_mem_top.sv
tests/tb_mem_top.sv

/* Makefile */
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Test OK

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "pass message missing from $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
